// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = cpuTb
FILELIST  = list.f

OBJDIR  = obj_dir
SIMBIN  = $(OBJDIR)/V$(TOP)
LOG     = sim.log
SOURCES = $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(SIMBIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIMBIN)
	-./$(SIMBIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx '>>> PASS' $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== bench/cpuTb.sv ====
`timescale 1ns/1ns

module cpuTb;
    logic clk;
    logic arstN;
    logic progWrEn;
    logic [cpuPkg::addrWidth-1:0] progAddr;
    logic [cpuPkg::instrWidth-1:0] progData;
    logic run;
    logic outValid;
    logic [cpuPkg::dataWidth-1:0] outData;
    logic halted;

    logic [15:0] prog [$];                  // Assembled program, word per address
    logic [7:0] expQ [$];                   // Expected OUT values in run order
    logic [7:0] model [16];                 // Register model
    logic [7:0] modelRam [logic [15:0]];    // Bytes stored by ST, keyed by pair address
    logic modelZero;
    logic [31:0] lfsrState = 32'he8d22f5f;
    int cycleCount = 0;
    int cycleLimit;

    cpuTop #(.ramDepthLog2(8), .romDepthLog2(8)) u_cpuTop (
        .clk(clk), .arstN(arstN), .progWrEn(progWrEn), .progAddr(progAddr),
        .progData(progData), .run(run), .outValid(outValid), .outData(outData),
        .halted(halted)
    );

    bind cpuTop cpuTbProps u_cpuTbProps (
        .clk(clk), .arstN(arstN), .run(run), .outValid(outValid), .halted(halted)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ********************
    // Random bytes
    // ********************
    function automatic logic [31:0] lfsrStep(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [7:0] randByte();
        logic [7:0] b;
        b = 8'h00;
        for (int i = 0; i < 8; i++) begin
            lfsrState = lfsrStep(lfsrState);    // One step per bit
            b = {b[6:0], lfsrState[0]};
        end
        return b;
    endfunction

    // Instruction words
    function automatic logic [15:0] regWord(int rd, int rb, cpuPkg::opcodeE op);
        return {rd[3:0], rb[3:0], 4'h0, op};
    endfunction

    function automatic logic [15:0] immWord(int rd, logic [7:0] imm, cpuPkg::opcodeE op);
        return {rd[3:0], imm, op};
    endfunction

    // ********************
    // Assembler with model
    // ********************
    task automatic loadImm(int rd, logic [7:0] value);
        prog.push_back(immWord(rd, value, cpuPkg::OP_LDI));
        model[rd] = value;
    endtask

    task automatic aluOp(cpuPkg::opcodeE op, int rd, int rb);
        logic [7:0] a;
        logic [7:0] b;
        a = model[rd];
        b = model[rb];
        case (op)
            cpuPkg::OP_ADD: model[rd] = a + b;  // Wraps at 8 bits
            cpuPkg::OP_SUB: model[rd] = a - b;
            cpuPkg::OP_AND: model[rd] = a & b;
            cpuPkg::OP_OR:  model[rd] = a | b;
            default:        model[rd] = b;      // MOV
        endcase
        if (op != cpuPkg::OP_MOV)
            modelZero = (model[rd] == 8'h00);   // MOV leaves flags alone
        prog.push_back(regWord(rd, rb, op));
    endtask

    task automatic addImm(int rd, logic [7:0] value);
        model[rd] = model[rd] + value;
        modelZero = (model[rd] == 8'h00);
        prog.push_back(immWord(rd, value, cpuPkg::OP_ADDI));
    endtask

    task automatic sendOut(int rd, logic reached);
        prog.push_back(regWord(rd, 0, cpuPkg::OP_OUT));
        if (reached)
            expQ.push_back(model[rd]);
    endtask

    task automatic storeByte(int rd, int rb);
        modelRam[{model[rb + 1], model[rb]}] = model[rd];
        prog.push_back(regWord(rd, rb, cpuPkg::OP_ST));
    endtask

    task automatic loadByte(int rd, int rb);
        model[rd] = modelRam[{model[rb + 1], model[rb]}];
        prog.push_back(regWord(rd, rb, cpuPkg::OP_LD));
    endtask

    task automatic jumpTo(logic [15:0] target);
        prog.push_back(regWord(0, 0, cpuPkg::OP_JMP));
        prog.push_back(target);                 // Second word
    endtask

    // Subroutine at the target sends r13 as its marker
    task automatic callSub(logic [15:0] target, int markReg);
        prog.push_back(regWord(0, 0, cpuPkg::OP_CALL));
        prog.push_back(target);
        expQ.push_back(model[markReg]);
    endtask

    task automatic buildProgram();
        logic [7:0] a;
        logic [7:0] b;
        logic [15:0] addrList [4];
        cpuPkg::opcodeE aluOps [4];
        aluOps = '{cpuPkg::OP_ADD, cpuPkg::OP_SUB, cpuPkg::OP_AND, cpuPkg::OP_OR};
        jumpTo(16'd5);                          // Over the dead OUT and the subroutine
        sendOut(0, 1'b0);
        sendOut(13, 1'b0);                      // Subroutine body at 3
        prog.push_back(regWord(0, 0, cpuPkg::OP_RET));
        for (int round = 0; round < 2; round++) begin
            for (int k = 0; k < 4; k++) begin
                loadImm(3, randByte());
                loadImm(4, randByte());
                aluOp(aluOps[k], 3, 4);
                sendOut(3, 1'b1);
            end
            addImm(3, randByte());
            sendOut(3, 1'b1);
            aluOp(cpuPkg::OP_MOV, 5, 3);
            sendOut(5, 1'b1);
        end
        loadImm(3, 8'hF0);
        addImm(3, 8'h25);                       // Forced wrap
        sendOut(3, 1'b1);
        // Stores below the stack bytes at the top of RAM
        for (int i = 0; i < 4; i++) begin
            a = randByte();
            b = randByte();
            addrList[i] = {a, 1'b0, i[1:0], b[4:0]};
            loadImm(6, addrList[i][7:0]);
            loadImm(7, addrList[i][15:8]);
            loadImm(8, randByte());
            storeByte(8, 6);
        end
        for (int i = 0; i < 4; i++) begin
            loadImm(6, addrList[i][7:0]);
            loadImm(7, addrList[i][15:8]);
            loadByte(9 + (i % 2), 6);
            sendOut(9 + (i % 2), 1'b1);
        end
        a = randByte();
        loadImm(1, a);
        loadImm(2, a);
        aluOp(cpuPkg::OP_SUB, 1, 2);            // Zero result
        prog.push_back(immWord(0, 8'd2, cpuPkg::OP_BZ));
        sendOut(1, !modelZero);
        loadImm(1, a);
        loadImm(2, a ^ 8'h5A);
        aluOp(cpuPkg::OP_SUB, 1, 2);            // Never zero
        prog.push_back(immWord(0, 8'd2, cpuPkg::OP_BZ));
        sendOut(1, !modelZero);
        for (int c = 0; c < 2; c++) begin
            loadImm(13, randByte());
            callSub(16'd3, 13);
            loadImm(5, randByte());
            sendOut(5, 1'b1);                   // Must follow the marker
        end
        prog.push_back(regWord(0, 0, cpuPkg::OP_HALT));
        sendOut(3, 1'b0);                       // Past HALT
    endtask

    // ********************
    // Checks
    // ********************
    task automatic stopOnError(string reason);
        $display("%s", reason);
        $display(">>> FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    always @(negedge clk) begin
        if (arstN && outValid) begin
            assert (expQ.size() > 0)
                else stopOnError("An output appeared when no further output was expected");
            assert (outData == expQ[0])
                else stopOnError($sformatf("** Error: outData = 0x%h, expected 0x%h",
                    outData, expQ[0]));
            void'(expQ.pop_front());
        end
    end

    always @(posedge clk) begin
        if (run)
            cycleCount <= cycleCount + 1;
    end

    initial begin
        arstN <= 1'b0;
        run <= 1'b0;
        progWrEn <= 1'b0;
        progAddr <= '0;
        progData <= '0;
        modelZero = 1'b0;
        for (int r = 0; r < 16; r++)
            model[r] = 8'h00;                   // Registers clear at reset
        buildProgram();
        cycleLimit = 8 * prog.size() + 200;
        repeat (8) @(posedge clk);
        arstN <= 1'b1;
        repeat (3) @(posedge clk);              // Idle before run
        for (int i = 0; i < prog.size(); i++) begin
            @(posedge clk);
            progWrEn <= 1'b1;
            progAddr <= 16'(i);
            progData <= prog[i];
        end
        @(posedge clk);
        progWrEn <= 1'b0;
        run <= 1'b1;
        while (!halted && cycleCount < cycleLimit)
            @(negedge clk);
        if (!halted) begin
            stopOnError($sformatf("Timeout: the core did not halt within %0d cycles",
                cycleLimit));
        end else begin
            repeat (4) @(negedge clk);          // Quiet after HALT
            if (expQ.size() == 0) begin
                $display(">>> PASS");
                $finish;
            end else begin
                stopOnError($sformatf("Halted with %0d expected outputs missing",
                    expQ.size()));
            end
        end
    end
endmodule

// ==== bench/cpuTb_props.sv ====
`timescale 1ns/1ns

module cpuTbProps (
    input logic clk,
    input logic arstN,
    input logic run,
    input logic outValid,
    input logic halted
);

    // ********************
    // Reset and idle
    // ********************
    quietInReset: assert property (
        @(posedge clk) !arstN |-> !outValid && !halted
    ) else $error("outValid or halted high while reset is held");

    // Core stopped until run rises
    quietBeforeRun: assert property (
        @(posedge clk) arstN && !run |-> !outValid && !halted
    ) else $error("outValid or halted high before run");

    // ********************
    // Halt
    // ********************
    haltSticky: assert property (
        @(posedge clk) disable iff (!arstN) halted |=> halted
    ) else $error("halted fell without a reset");

    noOutAfterHalt: assert property (
        @(posedge clk) disable iff (!arstN) halted |=> !outValid
    ) else $error("outValid rose after the core halted");

    // ********************
    // Output strobe
    // ********************
    singleStrobe: assert property (
        @(posedge clk) disable iff (!arstN) outValid |=> !outValid
    ) else $error("outValid held for two cycles");   // One cycle per OUT

endmodule

// ==== list.f ====
src/cpuPkg.sv
src/ctrlIf.sv
src/alu.sv
src/registerFile.sv
src/dataRam.sv
src/instrRom.sv
src/controlUnit.sv
src/cpuTop.sv
bench/cpuTb_props.sv
bench/cpuTb.sv

// ==== src/alu.sv ====
`timescale 1ns/1ns

module alu (
    input  logic [cpuPkg::dataWidth-1:0] dataA,
    input  logic [cpuPkg::dataWidth-1:0] dataB,
    input  cpuPkg::aluModeE mode,
    output logic [cpuPkg::dataWidth-1:0] result,
    output logic carry,
    output logic zero,
    output logic negative
);
    logic [cpuPkg::dataWidth:0] sum;    // One extra bit for carry out

    always_comb begin
        sum    = '0;
        result = dataB;
        carry  = 1'b0;
        case (mode)
            cpuPkg::ALU_ADD: begin
                sum    = {1'b0, dataA} + {1'b0, dataB};
                result = sum[cpuPkg::dataWidth-1:0];
                carry  = sum[cpuPkg::dataWidth];
            end
            cpuPkg::ALU_SUB: begin
                sum    = {1'b0, dataA} - {1'b0, dataB};
                result = sum[cpuPkg::dataWidth-1:0];
                carry  = ~sum[cpuPkg::dataWidth];   // Not-borrow
            end
            cpuPkg::ALU_AND: result = dataA & dataB;
            cpuPkg::ALU_OR:  result = dataA | dataB;
            default:         result = dataB;        // PASSB for MOV
        endcase
    end

    // Flags from the result
    assign zero     = (result == '0);
    assign negative = result[cpuPkg::dataWidth-1];
endmodule

// ==== src/controlUnit.sv ====
`timescale 1ns/1ns

module controlUnit (
    input  logic clk,
    input  logic arstN,
    input  logic run,
    input  logic [cpuPkg::instrWidth-1:0] instr,
    input  logic zeroFlag,
    ctrlIf.ctrl ctl,
    output logic halted
);
    cpuPkg::stateE state;
    cpuPkg::stateE nextState;
    cpuPkg::opcodeE opReg;              // Opcode held past DECODE
    cpuPkg::opcodeE newOp;              // Opcode straight off the ROM

    assign newOp = cpuPkg::opcodeE'(instr[cpuPkg::opHi:cpuPkg::opLo]);
    assign halted = (state == cpuPkg::HALTED);
    assign ctl.bSelect = instr[cpuPkg::rbHi:cpuPkg::rbLo];

    // ********************
    // State register
    // ********************
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= cpuPkg::FETCH;
            opReg <= cpuPkg::OP_NOP;
        end else if (run) begin
            state <= nextState;
            if (state == cpuPkg::DECODE)
                opReg <= newOp;         // Word 2 replaces the ROM output later
        end
    end

    always_comb begin
        nextState = cpuPkg::FETCH;
        case (state)
            cpuPkg::FETCH:  nextState = cpuPkg::DECODE;
            cpuPkg::DECODE: nextState = cpuPkg::EXEC;
            cpuPkg::EXEC: begin
                case (opReg)
                    cpuPkg::OP_LD:   nextState = cpuPkg::MEMWAIT;
                    cpuPkg::OP_JMP,
                    cpuPkg::OP_CALL: nextState = cpuPkg::WORD2;
                    cpuPkg::OP_RET:  nextState = cpuPkg::RET1;
                    cpuPkg::OP_HALT: nextState = cpuPkg::HALTED;
                    default:         nextState = cpuPkg::FETCH;
                endcase
            end
            cpuPkg::RET1:   nextState = cpuPkg::RET2;
            cpuPkg::HALTED: nextState = cpuPkg::HALTED;   // Sticky until reset
            default:        nextState = cpuPkg::FETCH;    // MEMWAIT, WORD2, RET2
        endcase
    end

    // ********************
    // Steering decode
    // ********************
    always_comb begin
        ctl.regFileSrc = 2'd0;
        ctl.regWriteEn = 1'b0;
        ctl.spInc      = 1'b0;
        ctl.spDec      = 1'b0;
        ctl.aluSrcB    = 1'b0;
        ctl.aluMode    = cpuPkg::ALU_PASSB;
        ctl.ramDataSel = 2'd2;
        ctl.ramAddrSel = 1'b0;
        ctl.ramWriteEn = 1'b0;
        ctl.flagEnable = 1'b0;
        ctl.pcSel      = 2'd0;
        ctl.pcWriteEn  = 1'b0;
        ctl.outStrobe  = 1'b0;
        if (run) begin
            case (state)
                cpuPkg::DECODE: begin
                    // Step past the opcode word so word 2 is read in EXEC
                    if (newOp == cpuPkg::OP_JMP || newOp == cpuPkg::OP_CALL)
                        ctl.pcWriteEn = 1'b1;
                end
                cpuPkg::EXEC: begin
                    ctl.pcWriteEn = 1'b1;               // Most ops just step
                    case (opReg)
                        cpuPkg::OP_LDI: begin
                            ctl.regFileSrc = 2'd1;
                            ctl.regWriteEn = 1'b1;
                        end
                        cpuPkg::OP_MOV: ctl.regWriteEn = 1'b1;  // PASSB of Rb
                        cpuPkg::OP_ADD, cpuPkg::OP_SUB, cpuPkg::OP_AND,
                        cpuPkg::OP_OR, cpuPkg::OP_ADDI: begin
                            ctl.regWriteEn = 1'b1;
                            ctl.flagEnable = 1'b1;
                            ctl.aluSrcB    = (opReg == cpuPkg::OP_ADDI);
                            case (opReg)
                                cpuPkg::OP_SUB: ctl.aluMode = cpuPkg::ALU_SUB;
                                cpuPkg::OP_AND: ctl.aluMode = cpuPkg::ALU_AND;
                                cpuPkg::OP_OR:  ctl.aluMode = cpuPkg::ALU_OR;
                                default:        ctl.aluMode = cpuPkg::ALU_ADD;
                            endcase
                        end
                        cpuPkg::OP_ST:  ctl.ramWriteEn = 1'b1;
                        cpuPkg::OP_OUT: ctl.outStrobe  = 1'b1;
                        cpuPkg::OP_BZ:  ctl.pcSel = zeroFlag ? 2'd2 : 2'd0;
                        cpuPkg::OP_CALL: begin
                            ctl.pcWriteEn  = 1'b0;
                            ctl.ramAddrSel = 1'b1;      // Push high byte
                            ctl.ramDataSel = 2'd0;
                            ctl.ramWriteEn = 1'b1;
                            ctl.spDec      = 1'b1;
                        end
                        cpuPkg::OP_RET: begin
                            ctl.pcWriteEn  = 1'b0;
                            ctl.ramAddrSel = 1'b1;      // Read low byte
                            ctl.spInc      = 1'b1;
                        end
                        cpuPkg::OP_LD, cpuPkg::OP_JMP,
                        cpuPkg::OP_HALT: ctl.pcWriteEn = 1'b0;
                        default: ;                      // NOP steps only
                    endcase
                end
                cpuPkg::MEMWAIT: begin
                    ctl.regFileSrc = 2'd2;              // Load data from RAM
                    ctl.regWriteEn = 1'b1;
                    ctl.pcWriteEn  = 1'b1;
                end
                cpuPkg::WORD2: begin
                    ctl.pcSel     = 2'd1;               // Target from word 2
                    ctl.pcWriteEn = 1'b1;
                    if (opReg == cpuPkg::OP_CALL) begin
                        ctl.ramAddrSel = 1'b1;          // Push low byte
                        ctl.ramDataSel = 2'd1;
                        ctl.ramWriteEn = 1'b1;
                        ctl.spDec      = 1'b1;
                    end
                end
                cpuPkg::RET1: begin
                    ctl.ramAddrSel = 1'b1;              // Read high byte
                    ctl.spInc      = 1'b1;
                end
                cpuPkg::RET2: begin
                    ctl.pcSel     = 2'd3;
                    ctl.pcWriteEn = 1'b1;
                end
                default: ;                              // FETCH, HALTED
            endcase
        end
    end
endmodule

// ==== src/cpuPkg.sv ====
package cpuPkg;

    // ********************
    // Widths
    // ********************
    localparam int dataWidth  = 8;      // Registers and data bytes
    localparam int addrWidth  = 16;     // PC and instruction addresses
    localparam int instrWidth = 16;     // One instruction word

    // Instruction fields
    localparam int rdHi  = 15;          // Destination register
    localparam int rdLo  = 12;
    localparam int immHi = 11;          // 8-bit immediate
    localparam int immLo = 4;
    localparam int rbHi  = 11;          // Source B, upper nibble of the immediate
    localparam int rbLo  = 8;
    localparam int opHi  = 3;           // Opcode
    localparam int opLo  = 0;

    // Stack pointer pair, r14 low and r15 high
    localparam logic [3:0] spLowReg = 4'd14;

    // ********************
    // Enums
    // ********************
    typedef enum logic [3:0] {
        OP_NOP, OP_LDI, OP_MOV, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_ADDI,
        OP_LD, OP_ST, OP_OUT, OP_JMP, OP_BZ, OP_CALL, OP_RET, OP_HALT
    } opcodeE;

    typedef enum logic [2:0] {
        ALU_PASSB, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR
    } aluModeE;

    typedef enum logic [2:0] {
        FETCH, DECODE, EXEC, MEMWAIT, WORD2, RET1, RET2, HALTED
    } stateE;

endpackage

// ==== src/cpuTop.sv ====
`timescale 1ns/1ns

module cpuTop #(
    parameter int ramDepthLog2 = 8,
    parameter int romDepthLog2 = 8
) (
    input  logic clk,
    input  logic arstN,
    input  logic progWrEn,
    input  logic [cpuPkg::addrWidth-1:0] progAddr,
    input  logic [cpuPkg::instrWidth-1:0] progData,
    input  logic run,
    output logic outValid,
    output logic [cpuPkg::dataWidth-1:0] outData,
    output logic halted
);
    ctrlIf ctl ();

    logic [cpuPkg::instrWidth-1:0] instr;       // ROM output, held while PC is still
    logic [cpuPkg::dataWidth-1:0] imm;
    logic [cpuPkg::dataWidth-1:0] regFileIn, outA, outB, outC;
    logic [cpuPkg::addrWidth-1:0] spOut, stackAddr;
    logic [cpuPkg::dataWidth-1:0] aluB, aluOut;
    logic aluCarry, aluZero, aluNegative;
    logic [cpuPkg::dataWidth-1:0] ramDin, ramDout;
    logic [cpuPkg::addrWidth-1:0] ramAddr;
    logic [2:0] statusReg;                      // {negative, zero, carry}
    logic [cpuPkg::dataWidth-1:0] returnReg;
    logic [cpuPkg::addrWidth-1:0] pc, pcPlusOne, pcBranch, pcNext;

    assign imm = instr[cpuPkg::immHi:cpuPkg::immLo];

    // ********************
    // Source muxes
    // ********************
    always_comb begin
        case (ctl.regFileSrc)
            2'd1:    regFileIn = imm;           // LDI
            2'd2:    regFileIn = ramDout;       // LD
            default: regFileIn = aluOut;
        endcase
    end

    assign aluB = ctl.aluSrcB ? imm : outB;     // ADDI takes the immediate

    always_comb begin
        case (ctl.ramDataSel)
            2'd0:    ramDin = pcPlusOne[15:8];  // Return address, high byte
            2'd1:    ramDin = pcPlusOne[7:0];
            default: ramDin = outA;             // ST source
        endcase
    end

    // Push writes below the current top
    assign stackAddr = ctl.spDec ? spOut - 1'b1 : spOut;
    assign ramAddr   = ctl.ramAddrSel ? stackAddr : {outC, outB};

    // ********************
    // Status and return registers
    // ********************
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN)
            statusReg <= '0;
        else if (ctl.flagEnable)
            statusReg <= {aluNegative, aluZero, aluCarry};
    end

    always_ff @(posedge clk) begin
        returnReg <= ramDout;                   // Popped low byte, seen in RET2
    end

    // ********************
    // PC
    // ********************
    assign pcPlusOne = pc + 1'b1;
    assign pcBranch  = pc + {{8{imm[7]}}, imm}; // Signed offset from BZ

    always_comb begin
        case (ctl.pcSel)
            2'd1:    pcNext = instr;            // Second word is the target
            2'd2:    pcNext = pcBranch;
            2'd3:    pcNext = {ramDout, returnReg};
            default: pcNext = pcPlusOne;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN)
            pc <= '0;
        else if (ctl.pcWriteEn)
            pc <= pcNext;
    end

    // Output port
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN)
            outValid <= 1'b0;
        else
            outValid <= ctl.outStrobe;
    end

    always_ff @(posedge clk) begin
        if (ctl.outStrobe)
            outData <= outA;
    end

    // ********************
    // Blocks
    // ********************
    controlUnit u_controlUnit (
        .clk(clk), .arstN(arstN), .run(run), .instr(instr),
        .zeroFlag(statusReg[1]), .ctl(ctl), .halted(halted)
    );

    registerFile u_registerFile (
        .clk(clk), .arstN(arstN),
        .wrSel(instr[cpuPkg::rdHi:cpuPkg::rdLo]), .bSelect(ctl.bSelect),
        .din(regFileIn), .writeEn(ctl.regWriteEn),
        .spInc(ctl.spInc), .spDec(ctl.spDec),
        .outA(outA), .outB(outB), .outC(outC), .spOut(spOut)
    );

    alu u_alu (
        .dataA(outA), .dataB(aluB), .mode(ctl.aluMode), .result(aluOut),
        .carry(aluCarry), .zero(aluZero), .negative(aluNegative)
    );

    dataRam #(.ramDepthLog2(ramDepthLog2)) u_dataRam (
        .clk(clk), .addr(ramAddr), .din(ramDin),
        .writeEn(ctl.ramWriteEn), .dout(ramDout)
    );

    instrRom #(.romDepthLog2(romDepthLog2)) u_instrRom (
        .clk(clk), .wrEn(progWrEn), .wrAddr(progAddr), .wrData(progData),
        .rdAddr(pc), .rdData(instr)             // FETCH presents the PC
    );
endmodule

// ==== src/ctrlIf.sv ====
`timescale 1ns/1ns

interface ctrlIf;
    // Register file
    logic [1:0] regFileSrc;            // 0 ALU, 1 immediate, 2 RAM
    logic regWriteEn;
    logic spInc;                       // Stack pair step up
    logic spDec;                       // Stack pair step down
    logic [3:0] bSelect;               // Source B register index
    // ALU
    logic aluSrcB;                     // 0 register, 1 immediate
    cpuPkg::aluModeE aluMode;
    // Data RAM
    logic [1:0] ramDataSel;            // 0 PC+1 high, 1 PC+1 low, 2 register
    logic ramAddrSel;                  // 0 register pair, 1 stack
    logic ramWriteEn;
    // Status and sequencing
    logic flagEnable;
    logic [1:0] pcSel;                 // 0 PC+1, 1 word 2, 2 branch, 3 return
    logic pcWriteEn;
    logic outStrobe;                   // One cycle per OUT

    modport ctrl (
        output regFileSrc, regWriteEn, spInc, spDec, bSelect,
        output aluSrcB, aluMode,
        output ramDataSel, ramAddrSel, ramWriteEn,
        output flagEnable, pcSel, pcWriteEn, outStrobe
    );

    modport dp (
        input regFileSrc, regWriteEn, spInc, spDec, bSelect,
        input aluSrcB, aluMode,
        input ramDataSel, ramAddrSel, ramWriteEn,
        input flagEnable, pcSel, pcWriteEn, outStrobe
    );
endinterface

// ==== src/dataRam.sv ====
`timescale 1ns/1ns

module dataRam #(
    parameter int ramDepthLog2 = 8
) (
    input  logic clk,
    input  logic [cpuPkg::addrWidth-1:0] addr,
    input  logic [cpuPkg::dataWidth-1:0] din,
    input  logic writeEn,
    output logic [cpuPkg::dataWidth-1:0] dout
);
    logic [cpuPkg::dataWidth-1:0] mem [2**ramDepthLog2];
    logic [ramDepthLog2-1:0] index;

    assign index = addr[ramDepthLog2-1:0];     // Upper bits fold back

    // Write and registered read share one address
    always_ff @(posedge clk) begin
        if (writeEn)
            mem[index] <= din;
        dout <= mem[index];
    end
endmodule

// ==== src/instrRom.sv ====
`timescale 1ns/1ns

module instrRom #(
    parameter int romDepthLog2 = 8
) (
    input  logic clk,
    input  logic wrEn,
    input  logic [cpuPkg::addrWidth-1:0] wrAddr,
    input  logic [cpuPkg::instrWidth-1:0] wrData,
    input  logic [cpuPkg::addrWidth-1:0] rdAddr,
    output logic [cpuPkg::instrWidth-1:0] rdData
);
    logic [cpuPkg::instrWidth-1:0] mem [2**romDepthLog2];

    // Load port, used while the core is stopped
    always_ff @(posedge clk) begin
        if (wrEn)
            mem[wrAddr[romDepthLog2-1:0]] <= wrData;
    end

    // One word per cycle, one cycle late
    always_ff @(posedge clk) begin
        rdData <= mem[rdAddr[romDepthLog2-1:0]];
    end
endmodule

// ==== src/registerFile.sv ====
`timescale 1ns/1ns

module registerFile (
    input  logic clk,
    input  logic arstN,
    input  logic [3:0] wrSel,               // Also the A read index
    input  logic [3:0] bSelect,
    input  logic [cpuPkg::dataWidth-1:0] din,
    input  logic writeEn,
    input  logic spInc,
    input  logic spDec,
    output logic [cpuPkg::dataWidth-1:0] outA,
    output logic [cpuPkg::dataWidth-1:0] outB,
    output logic [cpuPkg::dataWidth-1:0] outC,
    output logic [2*cpuPkg::dataWidth-1:0] spOut
);
    logic [cpuPkg::dataWidth-1:0] regs [16];
    logic [2*cpuPkg::dataWidth-1:0] spNext;

    // Combinational reads
    assign outA = regs[wrSel];
    assign outB = regs[bSelect];
    assign outC = regs[bSelect + 4'd1];     // High byte of the pair

    // ********************
    // Stack pointer pair
    // ********************
    assign spOut  = {regs[cpuPkg::spLowReg + 4'd1], regs[cpuPkg::spLowReg]};
    assign spNext = spInc ? spOut + 1'b1 : spOut - 1'b1;   // Carry or borrow into r15

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 16; i++)
                regs[i] <= '0;              // Empty stack sits at the top of RAM
        end else begin
            if (writeEn)
                regs[wrSel] <= din;
            if (spInc || spDec) begin
                regs[cpuPkg::spLowReg]        <= spNext[cpuPkg::dataWidth-1:0];
                regs[cpuPkg::spLowReg + 4'd1] <= spNext[2*cpuPkg::dataWidth-1:cpuPkg::dataWidth];
            end
        end
    end
endmodule
